// ==== bench/st_source_golden.txt ====
# columns: is_idle, then the idle count in hex for an idle directive,
# or sop eop empty data in hex for a data beat
0 1 0 0 a0000001
0 0 0 0 a0000002
0 0 1 1 a0000003
1 5
0 1 0 0 b1000001
0 0 0 0 b1000002
0 0 0 0 b1000003
0 0 1 2 b1000004
1 3
0 1 1 0 c2c2c2c2
1 a
0 1 0 0 d3000001
0 0 1 3 d3000002
1 0
0 1 0 0 e4000001
0 0 0 0 e4000002
0 0 1 1 e4000003
1 8
1 2
0 1 0 0 f5000001
0 0 0 0 f5000002
0 0 1 0 f5000003

// ==== bench/st_source_sva.sv ====
// bound concurrent assertions on the source port handshake, reset state and completion
`timescale 1ns/1ps
`include "st_source_defs.svh"

module st_source_sva (
   input logic                   clk,
   input logic                   reset,
   input logic                   src_valid,
   input logic                   src_ready,
   input logic [`ST_DATA_W-1:0]  src_data,
   input logic [`ST_EMPTY_W-1:0] src_empty,
   input logic                   src_startofpacket,
   input logic                   src_endofpacket,
   input logic                   rsp_valid,
   input logic                   complete
);

   // a stalled beat keeps every field until the sink takes it
   property beat_held;
      @(posedge clk) disable iff (reset)
         (src_valid && !src_ready) |=>
            (src_valid && $stable(src_data) && $stable(src_empty) &&
             $stable(src_startofpacket) && $stable(src_endofpacket));
   endproperty

   // quiet port and host side while reset is held
   property quiet_in_reset;
      @(posedge clk) (reset && $past(reset)) |-> (!src_valid && !rsp_valid && !complete);
   endproperty

   hold_a:  assert property (beat_held) else $error("source beat changed while stalled");
   reset_a: assert property (quiet_in_reset) else $error("outputs active during reset");
   // complete means the driver holds no beat
   done_a:  assert property (@(posedge clk) disable iff (reset) complete |-> !src_valid)
      else $error("complete high while a beat is shown");

endmodule

// ==== bench/tb_st_source.sv ====
// testbench for the streaming source, golden command replay under random back-pressure
`timescale 1ns/1ps
`include "st_source_defs.svh"

module tb_st_source
   import st_source_pkg::*;
();

   logic                   clk;
   logic                   reset;
   logic                   cmd_write;
   cmd_word_t              cmd_word;
   logic                   cmd_full;
   logic                   src_valid;
   logic [`ST_DATA_W-1:0]  src_data;
   logic [`ST_EMPTY_W-1:0] src_empty;
   logic                   src_startofpacket;
   logic                   src_endofpacket;
   logic                   src_ready;
   logic                   rsp_pop;
   logic                   rsp_valid;
   rsp_word_t              rsp_word;
   logic                   complete;

   // golden stimulus and the expectations derived from it
   cmd_word_t    cmd_q[$];
   beat_fields_t exp_beat_q[$];
   int           exp_gap_q[$];
   rsp_word_t    exp_rsp_q[$];
   int           ncmds;
   int           nbeats;
   int           idle_total;
   int           limit_cycles;

   // port monitor state
   int           beats_seen;
   int           rsp_seen;
   int           writes_done;
   int           low_cnt;
   int           wait_cnt;
   int           reset_cycles;
   logic         after_reset;
   logic         hold_pending;
   beat_fields_t held_beat;
   int           n_mismatch;
   int           n_fail;

   st_source_top dut_i (
      .clk               (clk),
      .reset             (reset),
      .cmd_write         (cmd_write),
      .cmd_word          (cmd_word),
      .cmd_full          (cmd_full),
      .src_valid         (src_valid),
      .src_data          (src_data),
      .src_empty         (src_empty),
      .src_startofpacket (src_startofpacket),
      .src_endofpacket   (src_endofpacket),
      .src_ready         (src_ready),
      .rsp_pop           (rsp_pop),
      .rsp_valid         (rsp_valid),
      .rsp_word          (rsp_word),
      .complete          (complete)
   );

   bind st_source_top st_source_sva sva_i (
      .clk               (clk),
      .reset             (reset),
      .src_valid         (src_valid),
      .src_ready         (src_ready),
      .src_data          (src_data),
      .src_empty         (src_empty),
      .src_startofpacket (src_startofpacket),
      .src_endofpacket   (src_endofpacket),
      .rsp_valid         (rsp_valid),
      .complete          (complete)
   );

   // 100 ns period
   always #50 clk = ~clk;

   task automatic print_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
      n_mismatch++;
      $display("MISMATCH t=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
   endtask

   task automatic note_failure(input string msg);
      n_fail++;
      $display("ERROR t=%0t %s", $time, msg);
   endtask

   // ---------------------------------------------------------------------
   // golden file, one command per line
   // ---------------------------------------------------------------------
   task automatic load_golden();
      int          fd;
      int          n;
      int          gap;
      string       line;
      logic [31:0] flag;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] d;
      cmd_word_t   w;
      fd  = $fopen("bench/st_source_golden.txt", "r");
      gap = 0;
      if (fd == 0) begin
         note_failure("cannot open bench/st_source_golden.txt");
      end else begin
         while ($fgets(line, fd) > 0) begin
            // comment and blank lines scan nothing
            n = $sscanf(line, "%h %h %h %h %h", flag, a, b, c, d);
            w = '0;
            if (n > 0 && flag == 32'd1 && n >= 2) begin
               w.is_idle            = 1'b1;
               w.body.idle.count    = a[`ST_IDLE_W-1:0];
               gap                  = gap + int'(a[`ST_IDLE_W-1:0]);
               idle_total           = idle_total + int'(a[`ST_IDLE_W-1:0]);
               cmd_q.push_back(w);
            end else if (n == 5 && flag == 32'd0) begin
               w.body.beat.startofpacket = a[0];
               w.body.beat.endofpacket   = b[0];
               w.body.beat.empty         = c[`ST_EMPTY_W-1:0];
               w.body.beat.data          = d;
               cmd_q.push_back(w);
               exp_beat_q.push_back(w.body.beat);
               // idle cycles owed before this beat
               exp_gap_q.push_back(gap);
               gap    = 0;
               nbeats = nbeats + 1;
            end else if (n > 0) begin
               note_failure($sformatf("malformed golden line: %s", line));
            end
         end
         $fclose(fd);
      end
      ncmds = cmd_q.size();
   endtask

   // random sink back-pressure, ready about two cycles in three
   always @(posedge clk) begin
      src_ready <= reset ? 1'b0 : (($urandom % 3) != 0);
   end

   // drain responses as soon as they show
   always @(posedge clk) begin
      rsp_pop <= reset ? 1'b0 : rsp_valid;
   end

   // ---------------------------------------------------------------------
   // port monitor, values sampled before the edge
   // ---------------------------------------------------------------------
   always @(posedge clk) begin : port_monitor
      beat_fields_t exp_b;
      rsp_word_t    exp_r;
      int           gap;
      if (reset) begin
         // first edge may precede the asynchronous reset taking hold
         if (reset_cycles > 0 && (src_valid || rsp_valid || complete)) begin
            note_failure("src_valid, rsp_valid or complete high during reset");
         end
         reset_cycles++;
         low_cnt      = 0;
         wait_cnt     = 0;
         writes_done  = 0;
         hold_pending = 1'b0;
         after_reset  = 1'b1;
      end else begin
         if (after_reset && (src_valid || rsp_valid || complete)) begin
            note_failure("src_valid, rsp_valid or complete high right after reset");
         end
         after_reset = 1'b0;
         // stalled beat from last cycle must be unchanged
         if (hold_pending) begin
            if (src_valid !== 1'b1) begin
               print_mismatch("src_valid (held)", 32'd1, 32'(src_valid));
            end
            if (src_data !== held_beat.data) begin
               print_mismatch("src_data (held)", held_beat.data, src_data);
            end
            if (src_empty !== held_beat.empty) begin
               print_mismatch("src_empty (held)", 32'(held_beat.empty), 32'(src_empty));
            end
            if (src_startofpacket !== held_beat.startofpacket) begin
               print_mismatch("src_startofpacket (held)", 32'(held_beat.startofpacket),
                              32'(src_startofpacket));
            end
            if (src_endofpacket !== held_beat.endofpacket) begin
               print_mismatch("src_endofpacket (held)", 32'(held_beat.endofpacket),
                              32'(src_endofpacket));
            end
         end
         hold_pending                = src_valid && !src_ready;
         held_beat.data              = src_data;
         held_beat.empty             = src_empty;
         held_beat.startofpacket     = src_startofpacket;
         held_beat.endofpacket       = src_endofpacket;
         // a full queue needs a whole depth of commands written and not yet taken as beats
         if (cmd_full === 1'b1 && (writes_done - beats_seen < `ST_CMD_DEPTH)) begin
            print_mismatch("cmd_full", 32'd0, 32'(cmd_full));
         end
         if (cmd_write && !cmd_full) begin
            writes_done++;
         end
         // response leaving the FIFO this edge
         if (rsp_pop && rsp_valid) begin
            if (exp_rsp_q.size() == 0) begin
               note_failure("response record without an accepted beat");
            end else begin
               exp_r = exp_rsp_q.pop_front();
               if (rsp_word.count !== exp_r.count) begin
                  print_mismatch("rsp_word.count", 32'(exp_r.count), 32'(rsp_word.count));
               end
               if (rsp_word.latency !== exp_r.latency) begin
                  print_mismatch("rsp_word.latency", 32'(exp_r.latency),
                                 32'(rsp_word.latency));
               end
            end
            rsp_seen++;
         end
         // handshake at latency 0
         if (src_valid && src_ready) begin
            if (exp_beat_q.size() == 0) begin
               note_failure("beat accepted beyond the golden list");
            end else begin
               exp_b = exp_beat_q.pop_front();
               gap   = exp_gap_q.pop_front();
               if (src_data !== exp_b.data) begin
                  print_mismatch("src_data", exp_b.data, src_data);
               end
               if (src_empty !== exp_b.empty) begin
                  print_mismatch("src_empty", 32'(exp_b.empty), 32'(src_empty));
               end
               if (src_startofpacket !== exp_b.startofpacket) begin
                  print_mismatch("src_startofpacket", 32'(exp_b.startofpacket),
                                 32'(src_startofpacket));
               end
               if (src_endofpacket !== exp_b.endofpacket) begin
                  print_mismatch("src_endofpacket", 32'(exp_b.endofpacket),
                                 32'(src_endofpacket));
               end
               if (low_cnt < gap) begin
                  note_failure($sformatf("beat %0d after %0d valid-low cycles, idle needs %0d",
                                         beats_seen, low_cnt, gap));
               end
            end
            exp_r.count   = beats_seen[`ST_COUNT_W-1:0];
            exp_r.latency = wait_cnt[`ST_LATENCY_W-1:0];
            exp_rsp_q.push_back(exp_r);
            beats_seen++;
            low_cnt  = 0;
            wait_cnt = 0;
         end else if (src_valid) begin
            wait_cnt++;
         end else begin
            low_cnt++;
         end
      end
   end

   // watchdog sized from the golden stimulus
   initial begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("ERROR watchdog expired after %0d cycles, %0d of %0d beats accepted",
               limit_cycles, beats_seen, nbeats);
      $display("summary: %0d beats, %0d responses, %0d mismatches, %0d other errors",
               beats_seen, rsp_seen, n_mismatch, n_fail);
      $display("TB FAILED");
      $finish;
   end

   // ---------------------------------------------------------------------
   // reset, command writes and final checks
   // ---------------------------------------------------------------------
   initial begin : main_flow
      int idx;
      void'($urandom(39469));
      clk          = 1'b0;
      reset        = 1'b1;
      cmd_write    = 1'b0;
      cmd_word     = '0;
      src_ready    = 1'b0;
      rsp_pop      = 1'b0;
      ncmds        = 0;
      nbeats       = 0;
      idle_total   = 0;
      beats_seen   = 0;
      rsp_seen     = 0;
      writes_done  = 0;
      reset_cycles = 0;
      n_mismatch   = 0;
      n_fail       = 0;
      load_golden();
      limit_cycles = (ncmds + idle_total + 64) * 8;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      // at most every other cycle, so a full flag seen here is never stale
      idx = 0;
      while (idx < ncmds) begin
         @(posedge clk);
         if (!cmd_full && !cmd_write) begin
            cmd_write <= 1'b1;
            cmd_word  <= cmd_q[idx];
            idx++;
         end else begin
            cmd_write <= 1'b0;
         end
      end
      @(posedge clk);
      cmd_write <= 1'b0;
      while (rsp_seen < nbeats) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
      if (complete !== 1'b1) begin
         note_failure("complete low after the last golden beat was accepted");
      end
      if (exp_beat_q.size() != 0 || exp_rsp_q.size() != 0) begin
         note_failure("golden beats or response records left unchecked");
      end
      $display("summary: %0d beats, %0d responses, %0d mismatches, %0d other errors",
               beats_seen, rsp_seen, n_mismatch, n_fail);
      if (n_mismatch == 0 && n_fail == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile the streaming source testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f src.f --top-module tb_st_source -Mdir obj_dir -o tb_st_source
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_st_source > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TB FAILED" "$log"; then
   echo "simulation reported failure"
   exit 1
fi

echo "simulation passed"
exit 0

// ==== src.f ====
+incdir+verilog
verilog/st_source_pkg.sv
verilog/st_fifo.sv
verilog/st_ready_align.sv
verilog/st_beat_driver.sv
verilog/st_latency_meter.sv
verilog/st_source_top.sv
bench/st_source_sva.sv
bench/tb_st_source.sv

// ==== verilog/st_beat_driver.sv ====
// command decode, idle countdown and source beat registers held under back-pressure
`timescale 1ns/1ps
`include "st_source_defs.svh"

module st_beat_driver
   import st_source_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  cmd_word_t              cmd_word,
   input  logic                   cmd_empty,
   output logic                   cmd_pop,
   input  logic                   ready_qualified,
   output logic                   src_valid,
   output logic [`ST_DATA_W-1:0]  src_data,
   output logic [`ST_EMPTY_W-1:0] src_empty,
   output logic                   src_startofpacket,
   output logic                   src_endofpacket,
   output logic                   accept,
   output logic                   waiting
);

   // with ready latency, valid may only show in a qualified cycle
   localparam bit gate_valid = (`ST_READY_LATENCY > 0);

   beat_fields_t          beat_q;
   logic                  beat_valid;
   logic [`ST_IDLE_W-1:0] idle_cnt;
   logic                  free;

   // ---------------------------------------------------------------------
   // handshake
   // ---------------------------------------------------------------------
   assign src_valid = beat_valid && (!gate_valid || ready_qualified);
   assign accept    = src_valid && ready_qualified;
   assign waiting   = beat_valid && !ready_qualified;

   // free when nothing is held and the idle count is spent,
   // or when the held beat leaves this cycle so the next one follows with no gap
   assign free    = (!beat_valid && (idle_cnt == '0)) || accept;
   assign cmd_pop = free && !cmd_empty;

   // port fields straight from the beat register
   assign src_data          = beat_q.data;
   assign src_empty         = beat_q.empty;
   assign src_startofpacket = beat_q.startofpacket;
   assign src_endofpacket   = beat_q.endofpacket;

   // ---------------------------------------------------------------------
   // load, hold and countdown
   // ---------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         beat_valid <= 1'b0;
         beat_q     <= '0;
         idle_cnt   <= '0;
      end else begin
         if (cmd_pop) begin
            // tag picks the view of the union
            if (cmd_word.is_idle) begin
               beat_valid <= 1'b0;
               beat_q     <= '0;
               idle_cnt   <= cmd_word.body.idle.count;
            end else begin
               beat_valid <= 1'b1;
               beat_q     <= cmd_word.body.beat;
            end
         end else if (free) begin
            // beat taken with nothing queued, outputs go low
            beat_valid <= 1'b0;
            beat_q     <= '0;
         end else if (idle_cnt != '0) begin
            idle_cnt <= idle_cnt - 1'b1;
         end
         // otherwise the held beat stays put under back-pressure
      end
   end

endmodule

// ==== verilog/st_fifo.sv ====
// synchronous first-word-fall-through FIFO with occupancy count
`timescale 1ns/1ps

module st_fifo #(
   parameter int width = 8,
   parameter int depth = 16
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             push,
   input  logic [width-1:0] wr_data,
   input  logic             pop,
   output logic [width-1:0] rd_data,
   output logic             empty,
   output logic             full
);

   localparam int aw = (depth > 1) ? $clog2(depth) : 1;
   localparam int cw = $clog2(depth + 1);

   logic [width-1:0] mem [depth];
   logic [aw-1:0]    wr_ptr;
   logic [aw-1:0]    rd_ptr;
   logic [cw-1:0]    count;
   logic             do_push;
   logic             do_pop;

   // pointers wrap at depth, which need not be a power of two
   function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] ptr);
      if (ptr == aw'(depth - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // push while full and pop while empty are dropped
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   assign empty   = (count == '0);
   assign full    = (count == cw'(depth));

   // head entry straight from the array
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // ---------------------------------------------------------------------
   // pointers and occupancy
   // ---------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== verilog/st_latency_meter.sv ====
// back-pressure cycle counter, response sequence counter and completion flag
`timescale 1ns/1ps
`include "st_source_defs.svh"

module st_latency_meter
   import st_source_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      accept,
   input  logic      waiting,
   input  logic      driver_busy,
   input  logic      cmd_empty,
   output logic      rsp_push,
   output rsp_word_t rsp_word,
   output logic      complete
);

   logic [`ST_LATENCY_W-1:0] wait_cnt;
   logic [`ST_COUNT_W-1:0]   seq_cnt;

   // ---------------------------------------------------------------------
   // counters and strobes
   // ---------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_cnt <= '0;
         seq_cnt  <= '0;
         rsp_push <= 1'b0;
         complete <= 1'b0;
      end else begin
         rsp_push <= accept;
         if (accept) begin
            // wait of the departing beat is captured below, start over
            wait_cnt <= '0;
            seq_cnt  <= seq_cnt + 1'b1;
         end else if (waiting && (wait_cnt != '1)) begin
            // saturate rather than wrap on a stuck sink
            wait_cnt <= wait_cnt + 1'b1;
         end
         // last beat gone and nothing queued behind it
         if (accept && cmd_empty) begin
            complete <= 1'b1;
         end else if (driver_busy || !cmd_empty) begin
            complete <= 1'b0;
         end
      end
   end

   // record of the accepted beat, pushed with rsp_push the next cycle
   always_ff @(posedge clk) begin
      if (accept) begin
         rsp_word.count   <= seq_cnt;
         rsp_word.latency <= wait_cnt;
      end
   end

endmodule

// ==== verilog/st_ready_align.sv ====
// src_ready delay line and qualified ready selection for the ready latency
`timescale 1ns/1ps
`include "st_source_defs.svh"

module st_ready_align (
   input  logic clk,
   input  logic reset,
   input  logic src_ready,
   output logic ready_qualified
);

   // stage k of the line holds src_ready from k+1 cycles back
   localparam int tap = (`ST_READY_LATENCY > 0) ? `ST_READY_LATENCY - 1 : 0;

   logic [`ST_MAX_READY_DELAY-1:0] ready_dly;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_dly <= '0;
      end else begin
         ready_dly <= {ready_dly[`ST_MAX_READY_DELAY-2:0], src_ready};
      end
   end

   // latency 0 bypasses the line entirely
   assign ready_qualified = (`ST_READY_LATENCY == 0) ? src_ready : ready_dly[tap];

endmodule

// ==== verilog/st_source_defs.svh ====
// width, depth and ready latency macros for the streaming source
`ifndef ST_SOURCE_DEFS_SVH
`define ST_SOURCE_DEFS_SVH

// ---------------------------------------------------------------------
// beat layout
// ---------------------------------------------------------------------
`define ST_SYMBOL_W        8
`define ST_NUMSYMBOLS      4
`define ST_DATA_W          (`ST_SYMBOL_W * `ST_NUMSYMBOLS)
`define ST_EMPTY_W         2

// idle directive count field
`define ST_IDLE_W          16

// ---------------------------------------------------------------------
// queue depths and response record fields
// ---------------------------------------------------------------------
`define ST_CMD_DEPTH       16
`define ST_RSP_DEPTH       16
`define ST_LATENCY_W       16
`define ST_COUNT_W         16

// ready latency, 0 up to the length of the delay line
`define ST_READY_LATENCY   0
`define ST_MAX_READY_DELAY 8

`endif

// ==== verilog/st_source_pkg.sv ====
// beat and idle field structs, command union, command word and response word types
`include "st_source_defs.svh"

package st_source_pkg;

   // ---------------------------------------------------------------------
   // command body, one 36 bit word read two ways
   // ---------------------------------------------------------------------

   // data beat as it appears on the source port
   typedef struct packed {
      logic                   startofpacket;
      logic                   endofpacket;
      logic [`ST_EMPTY_W-1:0] empty;
      logic [`ST_DATA_W-1:0]  data;
   } beat_fields_t;

   // idle directive, count sits in the low bits
   typedef struct packed {
      logic [`ST_DATA_W+`ST_EMPTY_W+2-`ST_IDLE_W-1:0] pad;
      logic [`ST_IDLE_W-1:0]                          count;
   } idle_fields_t;

   // the tag in cmd_word_t picks the view
   typedef union packed {
      beat_fields_t beat;
      idle_fields_t idle;
   } cmd_body_u;

   // one entry of the command FIFO
   typedef struct packed {
      logic      is_idle;
      cmd_body_u body;
   } cmd_word_t;

   // one entry of the response FIFO, back-pressure wait of one beat
   typedef struct packed {
      logic [`ST_COUNT_W-1:0]   count;
      logic [`ST_LATENCY_W-1:0] latency;
   } rsp_word_t;

endpackage

// ==== verilog/st_source_top.sv ====
// streaming source top with command and response FIFOs, ready aligner, driver and meter
`timescale 1ns/1ps
`include "st_source_defs.svh"

module st_source_top
   import st_source_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   // host command side
   input  logic                   cmd_write,
   input  cmd_word_t              cmd_word,
   output logic                   cmd_full,
   // source port
   output logic                   src_valid,
   output logic [`ST_DATA_W-1:0]  src_data,
   output logic [`ST_EMPTY_W-1:0] src_empty,
   output logic                   src_startofpacket,
   output logic                   src_endofpacket,
   input  logic                   src_ready,
   // host response side
   input  logic                   rsp_pop,
   output logic                   rsp_valid,
   output rsp_word_t              rsp_word,
   output logic                   complete
);

   cmd_word_t cmd_head;
   rsp_word_t rsp_rec;
   logic      cmd_empty;
   logic      cmd_pop;
   logic      ready_qualified;
   logic      accept;
   logic      waiting;
   logic      rsp_push;
   logic      rsp_empty;

   // ---------------------------------------------------------------------
   // command path
   // ---------------------------------------------------------------------
   st_fifo #(
      .width ($bits(cmd_word_t)),
      .depth (`ST_CMD_DEPTH)
   ) cmd_fifo_i (
      .clk     (clk),
      .reset   (reset),
      .push    (cmd_write),
      .wr_data (cmd_word),
      .pop     (cmd_pop),
      .rd_data (cmd_head),
      .empty   (cmd_empty),
      .full    (cmd_full)
   );

   st_ready_align ready_align_i (
      .clk             (clk),
      .reset           (reset),
      .src_ready       (src_ready),
      .ready_qualified (ready_qualified)
   );

   st_beat_driver beat_driver_i (
      .clk               (clk),
      .reset             (reset),
      .cmd_word          (cmd_head),
      .cmd_empty         (cmd_empty),
      .cmd_pop           (cmd_pop),
      .ready_qualified   (ready_qualified),
      .src_valid         (src_valid),
      .src_data          (src_data),
      .src_empty         (src_empty),
      .src_startofpacket (src_startofpacket),
      .src_endofpacket   (src_endofpacket),
      .accept            (accept),
      .waiting           (waiting)
   );

   // ---------------------------------------------------------------------
   // response path
   // ---------------------------------------------------------------------
   // driver holds work whenever it shows a beat
   st_latency_meter latency_meter_i (
      .clk         (clk),
      .reset       (reset),
      .accept      (accept),
      .waiting     (waiting),
      .driver_busy (src_valid),
      .cmd_empty   (cmd_empty),
      .rsp_push    (rsp_push),
      .rsp_word    (rsp_rec),
      .complete    (complete)
   );

   st_fifo #(
      .width ($bits(rsp_word_t)),
      .depth (`ST_RSP_DEPTH)
   ) rsp_fifo_i (
      .clk     (clk),
      .reset   (reset),
      .push    (rsp_push),
      .wr_data (rsp_rec),
      .pop     (rsp_pop),
      .rd_data (rsp_word),
      .empty   (rsp_empty),
      .full    ()
   );

   assign rsp_valid = !rsp_empty;

endmodule
